//--- Bender.yml
package:
  name: vdc

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vdcRegPkg.sv
      - rtl/vdcVideoPkg.sv
      - rtl/vdcRegisters.sv
      - rtl/vdcTiming.sv
      - rtl/vdcAddrGen.sv
      - rtl/vdcTop.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - verification/vdcTb.sv

//--- project.f
+incdir+rtl
rtl/vdcRegPkg.sv
rtl/vdcVideoPkg.sv
rtl/vdcRegisters.sv
rtl/vdcTiming.sv
rtl/vdcAddrGen.sv
rtl/vdcTop.sv
verification/vdcTb.sv

//--- rtl/vdcAddrGen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VDC address generator
// Screen memory fetch per displayed character and
// cursor match, once per character row
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module vdcAddrGen (
   input  logic                clk,
   input  logic                rst,
   input  logic                newFrame,
   input  logic                newRow,
   input  logic                newCol,
   input  logic                visible,
   input  vdcVideoPkg::memAddr ds,      // Display start
   input  vdcVideoPkg::memAddr cp,      // Cursor position
   input  vdcVideoPkg::memAddr ai,      // Extra row increment
   input  vdcRegPkg::charCount hd,
   output vdcVideoPkg::memAddr fetchAddr,
   output logic                fetchStrobe,
   output logic                cursorHit
);
   import vdcVideoPkg::*;

   memAddr rowStart, colAddr, rowNext, rowStep;
   logic   firstRow;                    // Next newRow is the top displayed row
   logic   armed;                       // Fetch run of this row still to come
   logic   visPrev;
   logic   fetchNow;

   assign rowStep  = {8'h00, hd} + ai;
   assign rowNext  = firstRow ? rowStart : rowStart + rowStep;
   assign fetchNow = newCol && visible && armed;

   always_ff @(posedge clk) begin
      if (rst) begin
         rowStart    <= '0;
         colAddr     <= '0;
         firstRow    <= 1'b1;
         armed       <= 1'b0;
         visPrev     <= 1'b0;
         fetchStrobe <= 1'b0;
      end else begin
         visPrev     <= visible;
         fetchStrobe <= fetchNow;
         if (newFrame) begin
            rowStart <= ds;
            colAddr  <= ds;
            firstRow <= 1'b1;
            armed    <= 1'b0;
         end else if (newRow) begin
            rowStart <= rowNext;
            colAddr  <= rowNext;
            firstRow <= 1'b0;
            armed    <= 1'b1;
         end else begin
            if (fetchNow) colAddr <= colAddr + 16'd1;
            if (armed && visPrev && !visible) armed <= 1'b0; // First line done
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fetchNow) fetchAddr <= colAddr;
   end

   assign cursorHit = fetchStrobe && (fetchAddr == cp);

endmodule

`default_nettype wire

//--- rtl/vdcRegPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VDC register types
// Host side index and data, and the widths of the
// fields decoded from the CRTC style registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package vdcRegPkg;

   // Register number as loaded into the address latch
   typedef logic [5:0] regIndex;

   // Register content, also the host data bus
   typedef logic [7:0] regByte;

   // Character or row count
   // HT, HD, HP, VT, VD, VP, DEB, DEE
   typedef logic [7:0] charCount;

   // Scan line count inside a character
   // CTV, VA, CDV, CS, CE, UL
   typedef logic [4:0] scanCount;

   // Four bit fields
   // HW, VW, CTH, CDH, FG, BG
   typedef logic [3:0] nibble;

endpackage

`default_nettype wire

//--- rtl/vdcRegisters.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VDC register file
// Address latch, register write and readback, and
// the field decode feeding the timing logic
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "vdc_settings.svh"

module vdcRegisters (
   input  logic                clk,
   input  logic                rst,
   input  logic                regSel,  // Load address latch
   input  logic                regWr,   // Write selected register
   input  logic                regRd,   // Request readback
   input  vdcRegPkg::regByte   dataIn,
   output vdcRegPkg::regByte   dataOut,
   output logic                initReq, // Geometry changed
   output vdcRegPkg::charCount ht,
   output vdcRegPkg::charCount hd,
   output vdcRegPkg::charCount hp,
   output vdcRegPkg::charCount vt,
   output vdcRegPkg::charCount vd,
   output vdcRegPkg::charCount vp,
   output vdcRegPkg::charCount deb,
   output vdcRegPkg::charCount dee,
   output vdcRegPkg::nibble    hw,
   output vdcRegPkg::nibble    vw,
   output vdcRegPkg::nibble    cth,
   output vdcRegPkg::nibble    bg,
   output vdcRegPkg::scanCount ctv,
   output vdcRegPkg::scanCount va,
   output vdcVideoPkg::memAddr ds,
   output vdcVideoPkg::memAddr cp,
   output vdcVideoPkg::memAddr ai
);
   import vdcRegPkg::*;

   // R36 and R37 start cleared
   localparam regByte rstValues [`VDC_NUM_REGS] = '{
      `VDC_RST_R0,  `VDC_RST_R1,  `VDC_RST_R2,  `VDC_RST_R3,  `VDC_RST_R4,  `VDC_RST_R5,
      `VDC_RST_R6,  `VDC_RST_R7,  `VDC_RST_R8,  `VDC_RST_R9,  `VDC_RST_R10, `VDC_RST_R11,
      `VDC_RST_R12, `VDC_RST_R13, `VDC_RST_R14, `VDC_RST_R15, `VDC_RST_R16, `VDC_RST_R17,
      `VDC_RST_R18, `VDC_RST_R19, `VDC_RST_R20, `VDC_RST_R21, `VDC_RST_R22, `VDC_RST_R23,
      `VDC_RST_R24, `VDC_RST_R25, `VDC_RST_R26, `VDC_RST_R27, `VDC_RST_R28, `VDC_RST_R29,
      `VDC_RST_R30, `VDC_RST_R31, `VDC_RST_R32, `VDC_RST_R33, `VDC_RST_R34, `VDC_RST_R35,
      8'h00,        8'h00
   };

   regByte  regs [`VDC_NUM_REGS];
   regIndex addrLatch;
   logic    addrValid;

   assign addrValid = (addrLatch < `VDC_NUM_REGS); // R38 and up are not implemented

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `VDC_NUM_REGS; i++) begin
            regs[i] <= rstValues[i];
         end
         addrLatch <= '0;
         initReq   <= 1'b0;
      end else begin
         if (regSel) addrLatch <= dataIn[5:0];
         if (regWr && addrValid) regs[addrLatch] <= dataIn; // Seen by timing next cycle
         // Restart counters on HT, VT or CTV change
         initReq <= regWr && (addrLatch == 6'd0 || addrLatch == 6'd4 || addrLatch == 6'd9);
      end
   end

   // Readback, held until the next request
   always_ff @(posedge clk) begin
      if (regRd) dataOut <= addrValid ? regs[addrLatch] : 8'hFF;
   end

   // Field decode
   assign ht  = regs[0];
   assign hd  = regs[1];
   assign hp  = regs[2];
   assign vw  = regs[3][7:4];
   assign hw  = regs[3][3:0];
   assign vt  = regs[4];
   assign va  = regs[5][4:0];
   assign vd  = regs[6];
   assign vp  = regs[7];
   assign ctv = regs[9][4:0];
   assign ds  = {regs[12], regs[13]};   // Hi byte first
   assign cp  = {regs[14], regs[15]};
   assign cth = regs[22][7:4];          // Low nibble is CDH
   assign bg  = regs[26][3:0];          // High nibble is FG
   assign ai  = {8'h00, regs[27]};
   assign deb = regs[34];
   assign dee = regs[35];

endmodule

`default_nettype wire

//--- rtl/vdcTiming.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VDC timing generator
// Dot, column, line, row and adjust counters with
// strobes, sync, blanking and test pattern colour
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module vdcTiming (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  init,     // Restart after geometry write
   input  logic                  enable,   // One dot per enabled cycle
   input  vdcRegPkg::charCount   ht,
   input  vdcRegPkg::charCount   hd,
   input  vdcRegPkg::charCount   hp,
   input  vdcRegPkg::charCount   vt,
   input  vdcRegPkg::charCount   vd,
   input  vdcRegPkg::charCount   vp,
   input  vdcRegPkg::charCount   deb,
   input  vdcRegPkg::charCount   dee,
   input  vdcRegPkg::nibble      hw,
   input  vdcRegPkg::nibble      vw,
   input  vdcRegPkg::nibble      cth,
   input  vdcRegPkg::nibble      bg,
   input  vdcRegPkg::scanCount   ctv,
   input  vdcRegPkg::scanCount   va,
   output logic                  newFrame,
   output logic                  newRow,   // Start of a displayed row only
   output logic                  newLine,
   output logic                  newCol,
   output logic                  visible,
   output logic                  hsync,
   output logic                  vsync,
   output logic                  hblank,
   output logic                  vblank,
   output vdcVideoPkg::rgbiColour rgbi
);
   import vdcRegPkg::*;
   import vdcVideoPkg::*;

   scanCount dot;
   charCount col, row;
   nibble    line;                  // Line inside the character row
   lineCount scanline;
   vertPhase phase;
   scanCount adjust;                // Adjust lines left
   charCount hCnt, vCnt;            // Display window columns and rows left
   nibble    hsCount;
   scanCount vsCount, vbCount;
   logic     pendFrame, pendRow, pendLine, pendCol;

   logic     colEnd, lineEnd, rowEnd, rowWrap, frameEnd;
   charCount nextCol, nextRow;
   lineCount nextScan, vbStart;
   scanCount vsWidth, vbWidth;

   assign colEnd   = (dot == ctv);
   assign lineEnd  = colEnd && (col == ht);
   assign rowEnd   = lineEnd && (phase == ROWS) && (line == cth);
   assign rowWrap  = rowEnd && (row == vt);     // Last character row
   assign frameEnd = (rowWrap && va == '0) ||
                     (lineEnd && phase == ADJUST && adjust == 5'd1);

   assign nextCol  = lineEnd ? '0 : col + 8'd1;
   assign nextRow  = frameEnd ? '0 : row + 8'd1;
   assign nextScan = frameEnd ? '0 : scanline + 9'd1;

   // Vertical blank opens four lines before vsync
   assign vbStart = lineCount'((cth + 9'd1) * vp) - 9'd4;
   assign vsWidth = (vw == '0) ? 5'd16 : scanCount'(vw); // Zero means 16 lines
   assign vbWidth = vsWidth + 5'd8;

   // Strobes fire in the enabled cycle after the event
   assign newFrame = enable && pendFrame;
   assign newRow   = enable && pendRow;
   assign newLine  = enable && pendLine;
   assign newCol   = enable && pendCol;

   assign visible = (hCnt != '0);
   assign hsync   = (hsCount != '0);
   assign vsync   = (vsCount != '0);
   assign vblank  = (vbCount != '0);

   // Black in blanking, col+row pattern in the window, border elsewhere
   assign rgbi = (hblank || vblank) ? '0 : (visible ? rgbiColour'(col + row) : bg);

   always_ff @(posedge clk) begin
      if (rst || init) begin
         dot       <= '0;
         col       <= '0;
         row       <= '0;
         line      <= '0;
         scanline  <= '0;
         phase     <= ROWS;
         adjust    <= '0;
         hCnt      <= '0;
         vCnt      <= '0;
         hsCount   <= '0;
         vsCount   <= '0;
         vbCount   <= '0;
         hblank    <= 1'b1;
         pendFrame <= 1'b1;       // First enabled cycle opens a frame
         pendRow   <= 1'b0;
         pendLine  <= 1'b1;
         pendCol   <= 1'b1;
      end else if (enable) begin
         pendFrame <= frameEnd;
         pendRow   <= rowEnd && !rowWrap && ((row == '0) ? (vd != '0) : (vCnt > 8'd1));
         pendLine  <= lineEnd;
         pendCol   <= colEnd;

         dot <= colEnd ? '0 : dot + 5'd1;

         if (colEnd) begin
            col <= nextCol;

            // Window opens at column 8 on displayed rows
            if (lineEnd) hCnt <= '0;
            else if (nextCol == 8'd8 && vCnt != '0) hCnt <= hd;
            else if (hCnt != '0) hCnt <= hCnt - 8'd1;

            if (nextCol == hp) hsCount <= hw;            // Sync covers column HP on
            else if (hsCount != '0) hsCount <= hsCount - 4'd1;

            if (nextCol == deb) hblank <= 1'b0;          // DEB wins on a tie
            else if (nextCol == dee) hblank <= 1'b1;
         end

         if (lineEnd) begin
            line     <= (rowEnd || frameEnd) ? '0 : line + 4'd1;
            scanline <= nextScan;
            if (rowEnd || frameEnd) row <= nextRow;

            // Displayed rows are 1 to VD
            if (rowWrap) vCnt <= '0;
            else if (rowEnd && row == '0) vCnt <= vd;
            else if (rowEnd && vCnt != '0) vCnt <= vCnt - 8'd1;

            // Adjust lines after the last row
            if (rowWrap && va != '0) begin
               phase  <= ADJUST;
               adjust <= va;
            end else if (phase == ADJUST) begin
               adjust <= adjust - 5'd1;
               if (adjust == 5'd1) phase <= ROWS;
            end

            if ((rowEnd || frameEnd) && nextRow == vp) vsCount <= vsWidth;
            else if (vsCount != '0) vsCount <= vsCount - 5'd1;

            if (nextScan == vbStart) vbCount <= vbWidth;
            else if (vbCount != '0) vbCount <= vbCount - 5'd1;
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/vdcTop.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VDC display timing core
// Register file, timing generator, address generator
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module vdcTop (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  dotEnable,
   input  logic                  regSel,
   input  logic                  regWr,
   input  logic                  regRd,
   input  vdcRegPkg::regByte     dataIn,
   output vdcRegPkg::regByte     dataOut,
   output logic                  hsync,
   output logic                  vsync,
   output logic                  hblank,
   output logic                  vblank,
   output logic                  visible,
   output vdcVideoPkg::rgbiColour rgbi,
   output vdcVideoPkg::memAddr   fetchAddr,
   output logic                  fetchStrobe,
   output logic                  cursorHit
);
   import vdcRegPkg::*;
   import vdcVideoPkg::*;

   charCount ht, hd, hp, vt, vd, vp, deb, dee;
   nibble    hw, vw, cth, bg;
   scanCount ctv, va;
   memAddr   ds, cp, ai;
   logic     initReq;
   logic     newFrame, newRow, newCol;

   vdcRegisters vdcRegisters_i (
      .clk, .rst, .regSel, .regWr, .regRd, .dataIn, .dataOut, .initReq,
      .ht, .hd, .hp, .vt, .vd, .vp, .deb, .dee,
      .hw, .vw, .cth, .bg, .ctv, .va, .ds, .cp, .ai
   );

   vdcTiming vdcTiming_i (
      .clk, .rst,
      .init    (initReq),
      .enable  (dotEnable),
      .ht, .hd, .hp, .vt, .vd, .vp, .deb, .dee,
      .hw, .vw, .cth, .bg, .ctv, .va,
      .newFrame, .newRow,
      .newLine (),              // Not needed without the memory side
      .newCol,
      .visible, .hsync, .vsync, .hblank, .vblank, .rgbi
   );

   vdcAddrGen vdcAddrGen_i (
      .clk, .rst, .newFrame, .newRow, .newCol, .visible,
      .ds, .cp, .ai, .hd,
      .fetchAddr, .fetchStrobe, .cursorHit
   );

endmodule

`default_nettype wire

//--- rtl/vdcVideoPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VDC video types
// Pixel colour, frame counters, memory address and
// the vertical phase of the timing generator
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package vdcVideoPkg;

   // Screen memory address
   typedef logic [15:0] memAddr;

   // Pixel as R, G, B, intensity
   typedef logic [3:0] rgbiColour;

   // Scan line within a frame
   typedef logic [8:0] lineCount;

   // Character rows, then the vertical adjust lines
   typedef enum logic {
      ROWS,
      ADJUST
   } vertPhase;

endpackage

`default_nettype wire

//--- rtl/vdc_settings.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VDC register file settings
// Register count and power-up register values
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef VDC_SETTINGS_SVH
`define VDC_SETTINGS_SVH

`define VDC_NUM_REGS 38      // R0 to R37

// Standard C128 values
`define VDC_RST_R0  8'h7E    // Horizontal total
`define VDC_RST_R1  8'h50    // Horizontal displayed
`define VDC_RST_R2  8'h66    // Horizontal sync position
`define VDC_RST_R3  8'h49    // Vsync width, hsync width
`define VDC_RST_R4  8'h20    // Vertical total
`define VDC_RST_R5  8'h00    // Vertical adjust
`define VDC_RST_R6  8'h19    // Vertical displayed
`define VDC_RST_R7  8'h1D    // Vertical sync position
`define VDC_RST_R8  8'h00
`define VDC_RST_R9  8'h07    // Character total vertical
`define VDC_RST_R10 8'h20
`define VDC_RST_R11 8'h07
`define VDC_RST_R12 8'h00    // Display start hi
`define VDC_RST_R13 8'h00
`define VDC_RST_R14 8'h00    // Cursor position hi
`define VDC_RST_R15 8'h00
`define VDC_RST_R16 8'h00
`define VDC_RST_R17 8'h00
`define VDC_RST_R18 8'h00
`define VDC_RST_R19 8'h00
`define VDC_RST_R20 8'h08
`define VDC_RST_R21 8'h00
`define VDC_RST_R22 8'h78    // Char total / displayed horizontal
`define VDC_RST_R23 8'h08
`define VDC_RST_R24 8'h20
`define VDC_RST_R25 8'h40
`define VDC_RST_R26 8'hF0    // Foreground white, background black
`define VDC_RST_R27 8'h00    // Row address increment
`define VDC_RST_R28 8'h20
`define VDC_RST_R29 8'h07
`define VDC_RST_R30 8'h00
`define VDC_RST_R31 8'h00
`define VDC_RST_R32 8'h00
`define VDC_RST_R33 8'h00
`define VDC_RST_R34 8'h7D    // Display enable begin
`define VDC_RST_R35 8'h64    // Display enable end

`endif

//--- verification/vdcTb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VDC display timing testbench
// Register readback, then a table of geometries run
// over one frame each with sync, fetch and colour checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "vdc_settings.svh"

module vdcTb;
   import vdcRegPkg::*;
   import vdcVideoPkg::*;

   typedef struct packed {
      scanCount ctv;
      nibble    cth;
      charCount ht;
      charCount hd;
      charCount hp;
      nibble    hw;
      charCount vt;
      charCount vd;
      charCount vp;
      nibble    vw;
      scanCount va;
      charCount deb;
      charCount dee;
      nibble    bg;
      memAddr   ds;
      regByte   ai;
      memAddr   cp;
   } geometry;

   // ctv cth ht hd hp hw vt vd vp vw va deb dee bg ds ai cp
   localparam geometry geometries [3] = '{
      '{5'd1, 4'd2, 8'd19, 8'd6, 8'd16, 4'd2, 8'd5, 8'd2, 8'd4, 4'd3, 5'd2,
        8'd6, 8'd16, 4'h6, 16'h0100, 8'h02, 16'h010B},     // Cursor on row 1
      '{5'd0, 4'd3, 8'd23, 8'd8, 8'd20, 4'd3, 8'd6, 8'd3, 8'd5, 4'd0, 5'd0,
        8'd5, 8'd18, 4'hA, 16'h2000, 8'h00, 16'h3000},     // VW 0, cursor outside
      '{5'd2, 4'd1, 8'd15, 8'd4, 8'd13, 4'd1, 8'd7, 8'd4, 8'd6, 4'd2, 5'd3,
        8'd7, 8'd13, 4'h3, 16'hFFF8, 8'h01, 16'h0002}      // Address wraps
   };

   localparam int riseTimeout = 6000;   // Cycles per vsync edge

   logic      clk;
   logic      rst;
   logic      dotEnable;
   logic      regSel, regWr, regRd;
   regByte    dataIn, dataOut;
   logic      hsync, vsync, hblank, vblank, visible;
   rgbiColour rgbi;
   memAddr    fetchAddr;
   logic      fetchStrobe, cursorHit;

   geometry cur;
   string   testName;
   int      valueErrors = 0;
   int      timeoutErrors = 0;
   logic    measuring = 1'b0;      // Inside the frame under test
   int      vsRises = 0;
   int      enCount, hsRun, vsRun, fetchCount, hitCount;
   int      hbRun, visRun, visLines;
   int      framePeriod, frameFetches, frameHits, frameVisLines;
   logic    hsPrev, vsPrev, hblankPrev, visiblePrev;

   vdcTop vdcTop_i (
      .clk, .rst, .dotEnable, .regSel, .regWr, .regRd, .dataIn, .dataOut,
      .hsync, .vsync, .hblank, .vblank, .visible, .rgbi,
      .fetchAddr, .fetchStrobe, .cursorHit
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // About three dots in four cycles
   initial begin : enableDriver
      dotEnable = 1'b0;
      void'($urandom(86));
      forever begin
         @(posedge clk);
         dotEnable <= ($urandom % 4) != 0;
      end
   end

   task automatic checkByte(input string what, input regByte expected, input regByte actual);
      if (expected !== actual) begin
         $display("FAILED %s %s: expected 0x%h, actual 0x%h", testName, what, expected, actual);
         valueErrors++;
      end
   endtask

   task automatic compareAddr(input string what, input memAddr expected, input memAddr actual);
      if (expected !== actual) begin
         $display("FAILED %s %s: expected 0x%h, actual 0x%h", testName, what, expected, actual);
         valueErrors++;
      end
   endtask

   task automatic verifyColour(input string what, input rgbiColour expected,
                               input rgbiColour actual);
      if (expected !== actual) begin
         $display("FAILED %s %s: expected 0x%h, actual 0x%h", testName, what, expected, actual);
         valueErrors++;
      end
   endtask

   task automatic matchCount(input string what, input int expected, input int actual);
      if (expected != actual) begin
         $display("FAILED %s %s: expected %0d, actual %0d", testName, what, expected, actual);
         valueErrors++;
      end
   endtask

   // Enabled cycles per frame, adjust lines included
   function automatic int framePeriodOf(input geometry g);
      return (int'(g.ctv) + 1) * (int'(g.ht) + 1) *
             ((int'(g.vt) + 1) * (int'(g.cth) + 1) + int'(g.va));
   endfunction

   function automatic int hsyncCycles(input geometry g);
      return int'(g.hw) * (int'(g.ctv) + 1);
   endfunction

   function automatic int vsyncCycles(input geometry g);
      int lines;
      lines = (g.vw == 4'd0) ? 16 : int'(g.vw);
      return lines * (int'(g.ht) + 1) * (int'(g.ctv) + 1);
   endfunction

   // Columns DEB up to DEE are unblanked
   function automatic int unblankedCycles(input geometry g);
      return (int'(g.dee) - int'(g.deb)) * (int'(g.ctv) + 1);
   endfunction

   function automatic int windowCycles(input geometry g);
      return int'(g.hd) * (int'(g.ctv) + 1);
   endfunction

   // Fetch n of a frame, row by row
   function automatic memAddr fetchAddrAt(input geometry g, input int n);
      int row, column;
      row    = n / int'(g.hd);
      column = n % int'(g.hd);
      return memAddr'(int'(g.ds) + row * (int'(g.hd) + int'(g.ai)) + column);
   endfunction

   function automatic int cursorHits(input geometry g);
      int hits, n;
      hits = 0;
      for (n = 0; n < int'(g.vd) * int'(g.hd); n++) begin
         if (fetchAddrAt(g, n) == g.cp) hits++;
      end
      return hits;
   endfunction

   task automatic writeReg(input regIndex idx, input regByte value);
      @(posedge clk);
      regSel <= 1'b1;
      dataIn <= {2'b00, idx};
      @(posedge clk);
      regSel <= 1'b0;
      regWr  <= 1'b1;
      dataIn <= value;
      @(posedge clk);
      regWr  <= 1'b0;
   endtask

   task automatic readReg(input regIndex idx, output regByte value);
      @(posedge clk);
      regSel <= 1'b1;
      dataIn <= {2'b00, idx};
      @(posedge clk);
      regSel <= 1'b0;
      regRd  <= 1'b1;
      @(posedge clk);
      regRd  <= 1'b0;
      @(negedge clk);               // dataOut settled one cycle after regRd
      value = dataOut;
   endtask

   task automatic programGeometry(input geometry g);
      writeReg(6'd0, g.ht);
      writeReg(6'd1, g.hd);
      writeReg(6'd2, g.hp);
      writeReg(6'd3, {g.vw, g.hw});
      writeReg(6'd4, g.vt);
      writeReg(6'd5, {3'b000, g.va});
      writeReg(6'd6, g.vd);
      writeReg(6'd7, g.vp);
      writeReg(6'd9, {3'b000, g.ctv});
      writeReg(6'd12, g.ds[15:8]);
      writeReg(6'd13, g.ds[7:0]);
      writeReg(6'd14, g.cp[15:8]);
      writeReg(6'd15, g.cp[7:0]);
      writeReg(6'd22, {g.cth, 4'h0});
      writeReg(6'd26, {4'hF, g.bg});
      writeReg(6'd27, g.ai);
      writeReg(6'd34, g.deb);
      writeReg(6'd35, g.dee);
   endtask

   task automatic waitRises(input int target, output logic ok);
      int cycles;
      cycles = 0;
      while (vsRises < target && cycles < riseTimeout) begin
         @(posedge clk);
         cycles++;
      end
      ok = (vsRises >= target);
      if (!ok) $display("Timeout in %s: no vsync edge within %0d cycles", testName, riseTimeout);
   endtask

   // Frame stats, widths, fetches and colour, all sampled mid cycle
   always @(negedge clk) begin
      if (rst) begin
         enCount     = 0;
         hsRun       = 0;
         vsRun       = 0;
         hbRun       = 0;
         visRun      = 0;
         visLines    = 0;
         fetchCount  = 0;
         hitCount    = 0;
         hsPrev      = 1'b0;
         vsPrev      = 1'b0;
         hblankPrev  = 1'b1;
         visiblePrev = 1'b0;
      end else begin
         if (vsync && !vsPrev) begin           // Frame boundary
            framePeriod   = enCount;
            frameFetches  = fetchCount;
            frameHits     = hitCount;
            frameVisLines = visLines;
            enCount       = 0;
            fetchCount    = 0;
            hitCount      = 0;
            visLines      = 0;
            vsRises++;
         end
         if (dotEnable) enCount++;
         if (hsync && dotEnable) hsRun++;
         if (vsync && dotEnable) vsRun++;
         if (!hblank && dotEnable) hbRun++;
         if (visible && dotEnable) visRun++;
         if (!hsync && hsPrev) begin
            if (measuring) matchCount("hsync width", hsyncCycles(cur), hsRun);
            hsRun = 0;
         end
         if (!vsync && vsPrev) begin
            if (measuring) matchCount("vsync width", vsyncCycles(cur), vsRun);
            vsRun = 0;
         end
         if (hblank && !hblankPrev) begin     // Rises at DEE
            if (measuring) matchCount("unblanked width", unblankedCycles(cur), hbRun);
            hbRun = 0;
         end
         if (!visible && visiblePrev) begin
            if (measuring) matchCount("window width", windowCycles(cur), visRun);
            visRun = 0;
         end
         if (visible && !visiblePrev) visLines++;
         if (measuring && vsync) matchCount("vblank during vsync", 1, int'(vblank));
         if (fetchStrobe) begin
            if (measuring) compareAddr("fetch address", fetchAddrAt(cur, fetchCount), fetchAddr);
            fetchCount++;
         end
         if (cursorHit) hitCount++;
         if (measuring) begin
            if (hblank || vblank) verifyColour("blank colour", 4'h0, rgbi);
            else if (!visible) verifyColour("border colour", cur.bg, rgbi);
         end
         hsPrev      = hsync;
         vsPrev      = vsync;
         hblankPrev  = hblank;
         visiblePrev = visible;
      end
   end

   initial begin : mainFlow
      regByte value;
      logic   ok;
      int     startRises;
      int     i;
      rst    = 1'b1;
      regSel = 1'b0;
      regWr  = 1'b0;
      regRd  = 1'b0;
      dataIn = '0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      testName = "readback";
      readReg(6'd22, value);
      checkByte("reset value R22", `VDC_RST_R22, value);
      writeReg(6'd20, 8'hA5);
      readReg(6'd20, value);
      checkByte("written R20", 8'hA5, value);
      readReg(6'd40, value);
      checkByte("unimplemented R40", 8'hFF, value);

      for (i = 0; i < 3; i++) begin
         cur      = geometries[i];
         testName = $sformatf("geometry %0d", i);
         programGeometry(cur);
         startRises = vsRises;
         waitRises(startRises + 1, ok);      // Skip the frame cut by the restart
         if (ok) begin
            measuring = 1'b1;
            waitRises(startRises + 2, ok);
            measuring = 1'b0;
         end
         if (ok) begin
            matchCount("frame period", framePeriodOf(cur), framePeriod);
            matchCount("fetches per frame", int'(cur.vd) * int'(cur.hd), frameFetches);
            matchCount("cursor hits", cursorHits(cur), frameHits);
            matchCount("window lines", int'(cur.vd) * (int'(cur.cth) + 1), frameVisLines);
         end else begin
            timeoutErrors++;
         end
      end

      $display("Errors: %0d value, %0d timeout", valueErrors, timeoutErrors);
      if (valueErrors == 0 && timeoutErrors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
